//--- dv/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_checker #(
	parameter int INDEX_BITS = 6
) (
	input  wire                 i_clock,
	input  wire                 i_reset,
	input  wire                 i_hold,
	input  wire                 i_redirect,
	input  wire bus_pkg::word_t i_redirect_pc,
	input  wire                 i_instr_valid,
	input  wire bus_pkg::word_t i_instr,
	input  wire bus_pkg::word_t i_instr_pc,
	input  wire                 i_bus_request,
	input  wire bus_pkg::word_t i_bus_address,
	input  wire bus_pkg::word_t i_hit_count,
	input  wire bus_pkg::word_t i_miss_count,
	input  wire                 i_check,
	input  wire bus_pkg::word_t i_expect_hits,
	input  wire bus_pkg::word_t i_expect_misses,
	output int                  o_error_count
);
	import bus_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;
	localparam int STIM_DEPTH = 256;

	word_t image [STIM_DEPTH];
	word_t tags [LINES];
	logic  line_valid [LINES];
	word_t expected_pc;
	word_t redirect_target;
	logic  redirect_armed;
	int    cycle;
	int    redirect_cycle;
	word_t model_hits;
	word_t model_misses;
	logic  was_quiet;

	// Word 0 of the file is the image length, the image follows.
	function automatic word_t memory_word(word_t address);
		word_t word_index;
		word_index = {2'b00, address[31:2]};
		if (word_index < image[0]) begin
			return image[word_index[7:0] + 8'd1];
		end
		return ~address ^ 32'h5a5a_0000;
	endfunction

	task automatic report_failure(string message);
		$display("FAILED at %0t ns: %s", $time, message);
		o_error_count++;
	endtask

	// Direct-mapped tag model, one word per line.
	task automatic record_fetch(word_t pc);
		logic [INDEX_BITS-1:0] index;
		index = pc[INDEX_BITS+1:2];
		if (line_valid[index] && tags[index] == pc) begin
			model_hits = model_hits + 32'd1;
		end else begin
			model_misses = model_misses + 32'd1;
			line_valid[index] = 1'b1;
			tags[index] = pc;
		end
	endtask

	function automatic logic is_cached(word_t address);
		logic [INDEX_BITS-1:0] index;
		index = address[INDEX_BITS+1:2];
		return line_valid[index] && tags[index] == address;
	endfunction

	initial begin
		$readmemh("dv/fetch_stimulus.txt", image);
		o_error_count = 0;
		cycle = 0;
	end

	// All DUT outputs and testbench drives are settled at the falling edge.
	always @(negedge i_clock) begin
		cycle = cycle + 1;
		if (i_reset) begin
			for (int i = 0; i < LINES; i++) begin
				line_valid[i] = 1'b0;
				tags[i] = '0;
			end
			expected_pc = RESET_PC;
			redirect_armed = 1'b0;
			model_hits = '0;
			model_misses = '0;
			was_quiet = 1'b0;
		end else begin
			if (i_instr_valid) begin
				if (was_quiet) begin
					report_failure("instruction delivered while hold was high");
				end
				// First ready after the redirect carries the dropped word.
				if (redirect_armed && cycle > redirect_cycle + 2) begin
					record_fetch(expected_pc);
					expected_pc = redirect_target;
					redirect_armed = 1'b0;
				end
				if (i_instr_pc !== expected_pc) begin
					report_failure($sformatf("pc %h, expected %h", i_instr_pc, expected_pc));
				end
				if (i_instr !== memory_word(expected_pc)) begin
					report_failure($sformatf("instruction %h at pc %h, expected %h",
						i_instr, expected_pc, memory_word(expected_pc)));
				end
				record_fetch(expected_pc);
				expected_pc = expected_pc + 32'd4;
			end
			if (i_redirect) begin
				redirect_armed = 1'b1;
				redirect_target = {i_redirect_pc[31:2], 2'b00};
				redirect_cycle = cycle;
			end
			if (i_bus_request && is_cached(i_bus_address)) begin
				report_failure($sformatf("bus request for cached address %h", i_bus_address));
			end
			if (i_check) begin
				if (i_hit_count !== model_hits || i_hit_count !== i_expect_hits) begin
					report_failure($sformatf("hit count %0d, model %0d, file %0d",
						i_hit_count, model_hits, i_expect_hits));
				end
				if (i_miss_count !== model_misses || i_miss_count !== i_expect_misses) begin
					report_failure($sformatf("miss count %0d, model %0d, file %0d",
						i_miss_count, model_misses, i_expect_misses));
				end
			end
			was_quiet = i_hold && !i_bus_request;
		end
	end

endmodule

`default_nettype wire

//--- dv/fetch_stimulus.txt
// Word 0: image length in words, then the image from address 0.
// Then command pairs, opcode and argument: 1 run, 2 redirect, 3 hold, 4 reset,
// 5 expect counts (hits in upper half, misses in lower half), 0 end.
00000010
13000093
00100113
002081b3
00418233
fe000ee3
00c12283
01c12303
00730393
40530433
0080a023
abad1dea
cafe0001
5a5a0f0f
0ff00ff0
12345678
87654321
00000001 00000008
00000005 00000008
00000002 00000000
00000001 00000004
00000005 00050009
00000003 00000005
00000001 00000004
00000005 0009000a
00000004 00000000
00000005 00000000
00000001 00000002
00000005 00000002
00000002 00000038
00000001 00000002
00000005 00000005
00000000 00000000

//--- dv/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
	import bus_pkg::*;

	localparam int INDEX_BITS = 6;
	localparam int LINES = 1 << INDEX_BITS;
	localparam int STIM_DEPTH = 256;

	logic  clock = 1'b0;
	logic  reset;
	logic  hold;
	logic  redirect;
	word_t redirect_pc;
	logic  bus_ready;
	word_t bus_rdata;
	logic  check;
	word_t expect_hits;
	word_t expect_misses;
	wire   instr_valid;
	word_t instr;
	word_t instr_pc;
	wire   bus_request;
	word_t bus_address;
	word_t hit_count;
	word_t miss_count;
	int    error_count;

	word_t stim [STIM_DEPTH];
	logic [31:0] lfsr_state = 32'hdc44;

	always #5 clock = ~clock;

	fetch_top #(
		.INDEX_BITS (INDEX_BITS)
	) fetch_top_inst (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_hold        (hold),
		.i_redirect    (redirect),
		.i_redirect_pc (redirect_pc),
		.o_instr_valid (instr_valid),
		.o_instr       (instr),
		.o_instr_pc    (instr_pc),
		.o_bus_request (bus_request),
		.o_bus_address (bus_address),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.o_hit_count   (hit_count),
		.o_miss_count  (miss_count)
	);

	fetch_checker #(
		.INDEX_BITS (INDEX_BITS)
	) checker_inst (
		.i_clock         (clock),
		.i_reset         (reset),
		.i_hold          (hold),
		.i_redirect      (redirect),
		.i_redirect_pc   (redirect_pc),
		.i_instr_valid   (instr_valid),
		.i_instr         (instr),
		.i_instr_pc      (instr_pc),
		.i_bus_request   (bus_request),
		.i_bus_address   (bus_address),
		.i_hit_count     (hit_count),
		.i_miss_count    (miss_count),
		.i_check         (check),
		.i_expect_hits   (expect_hits),
		.i_expect_misses (expect_misses),
		.o_error_count   (error_count)
	);

	function automatic logic [31:0] lfsr_step(logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// Addresses past the image return a pattern of the full address.
	function automatic word_t memory_word(word_t address);
		word_t word_index;
		word_index = {2'b00, address[31:2]};
		if (word_index < stim[0]) begin
			return stim[word_index[7:0] + 8'd1];
		end
		return ~address ^ 32'h5a5a_0000;
	endfunction

	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
	endtask

	// Runs until n words are delivered, then holds and lets an open fill finish.
	task automatic run_instructions(int n);
		int count;
		count = 0;
		@(posedge clock);
		hold <= 1'b0;
		while (count < n) begin
			@(negedge clock);
			if (instr_valid) begin
				count++;
			end
		end
		@(posedge clock);
		hold <= 1'b1;
		repeat (2) @(negedge clock);
		while (bus_request) begin
			@(negedge clock);
		end
		repeat (2) @(negedge clock);
	endtask

	task automatic hold_cycles(int n);
		@(posedge clock);
		hold <= 1'b1;
		repeat (n) @(posedge clock);
	endtask

	task automatic redirect_to(word_t target);
		@(posedge clock);
		redirect <= 1'b1;
		redirect_pc <= target;
		@(posedge clock);
		redirect <= 1'b0;
	endtask

	task automatic check_counts(word_t packed_counts);
		@(posedge clock);
		expect_hits <= {16'd0, packed_counts[31:16]};
		expect_misses <= {16'd0, packed_counts[15:0]};
		check <= 1'b1;
		@(posedge clock);
		check <= 1'b0;
	endtask

	// Bus memory with a random wait of 0 to 3 cycles.
	initial begin
		word_t address;
		logic [1:0] delay;
		bus_ready = 1'b0;
		bus_rdata = '0;
		forever begin
			@(negedge clock);
			if (bus_request && !reset) begin
				address = bus_address;
				delay = 2'd0;
				repeat (2) begin
					lfsr_state = lfsr_step(lfsr_state);
					delay = {delay[0], lfsr_state[0]};
				end
				repeat (delay) @(posedge clock);
				@(posedge clock);
				bus_ready <= 1'b1;
				bus_rdata <= memory_word(address);
				@(posedge clock);
				bus_ready <= 1'b0;
			end
		end
	end

	initial begin
		int pos;
		int run_total;
		int hold_total;
		int resets;
		int limit;
		int bad_commands;
		reset = 1'b1;
		hold = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		check = 1'b0;
		expect_hits = '0;
		expect_misses = '0;
		bad_commands = 0;
		$readmemh("dv/fetch_stimulus.txt", stim);

		run_total = 0;
		hold_total = 0;
		resets = 1;
		pos = int'(stim[0]) + 1;
		while (stim[pos] != 32'd0 && pos < STIM_DEPTH - 1) begin
			if (stim[pos] == 32'd1) run_total += int'(stim[pos+1]);
			if (stim[pos] == 32'd3) hold_total += int'(stim[pos+1]);
			if (stim[pos] == 32'd4) resets++;
			pos += 2;
		end
		limit = run_total * 8 + resets * LINES + hold_total + 200;

		fork
			begin
				repeat (limit) @(posedge clock);
				$display("Timeout: the command list did not finish within %0d cycles", limit);
				$display("tests failed");
				$finish;
			end
		join_none

		apply_reset();
		pos = int'(stim[0]) + 1;
		while (stim[pos] != 32'd0 && pos < STIM_DEPTH - 1) begin
			case (stim[pos])
				32'd1: run_instructions(int'(stim[pos+1]));
				32'd2: redirect_to(stim[pos+1]);
				32'd3: hold_cycles(int'(stim[pos+1]));
				32'd4: apply_reset();
				32'd5: check_counts(stim[pos+1]);
				default: begin
					$display("Unknown command %h in the stimulus file", stim[pos]);
					bad_commands++;
				end
			endcase
			pos += 2;
		end
		repeat (2) @(posedge clock);

		$display("Run finished with %0d errors and %0d unknown commands",
			error_count, bad_commands);
		if (error_count == 0 && bad_commands == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- fetch.f
hw/bus_pkg.sv
hw/icache_pkg.sv
hw/fetch_if.sv
hw/cache_ram.sv
hw/icache.sv
hw/fetch_unit.sv
hw/fetch_top.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

//--- hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// Widths of the external memory bus.
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// One bus word, used for both addresses and instruction data.
	typedef logic [DATA_WIDTH-1:0] word_t;

	// Fetch starts here after every reset.
	localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

//--- hw/cache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
	parameter int INDEX_BITS = 6
) (
	input  wire                     i_clock,
	input  wire                     i_write,
	input  wire [INDEX_BITS-1:0]    i_index,
	input  wire icache_pkg::entry_t i_wdata,
	output icache_pkg::entry_t      o_rdata
);
	import icache_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;

	entry_t mem [LINES];

	// Read every cycle, old data on a write to the same line.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_index] <= i_wdata;
		end
		o_rdata <= mem[i_index];
	end

endmodule

`default_nettype wire

//--- hw/fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;
	import bus_pkg::*;

	word_t pc;
	logic  hold;
	// Single-cycle strobe; rdata is only meaningful while it is high.
	logic  ready;
	word_t rdata;

	modport fetch_unit (
		output pc,
		output hold,
		input  ready,
		input  rdata
	);

	modport icache (
		input  pc,
		input  hold,
		output ready,
		output rdata
	);

endinterface

`default_nettype wire

//--- hw/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
	parameter int INDEX_BITS = 6
) (
	input  wire                 i_clock,
	input  wire                 i_reset,
	input  wire                 i_hold,
	input  wire                 i_redirect,
	input  wire bus_pkg::word_t i_redirect_pc,
	output wire                 o_instr_valid,
	output wire bus_pkg::word_t o_instr,
	output wire bus_pkg::word_t o_instr_pc,
	output wire                 o_bus_request,
	output wire bus_pkg::word_t o_bus_address,
	input  wire                 i_bus_ready,
	input  wire bus_pkg::word_t i_bus_rdata,
	output wire bus_pkg::word_t o_hit_count,
	output wire bus_pkg::word_t o_miss_count
);
	import icache_pkg::*;

	logic ram_write;
	logic [INDEX_BITS-1:0] ram_index;
	entry_t ram_wdata;
	entry_t ram_rdata;

	fetch_if fetch_bus ();

	fetch_unit fetch_unit_inst (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_hold        (i_hold),
		.i_redirect    (i_redirect),
		.i_redirect_pc (i_redirect_pc),
		.fetch         (fetch_bus),
		.o_instr_valid (o_instr_valid),
		.o_instr       (o_instr),
		.o_instr_pc    (o_instr_pc)
	);

	icache #(
		.INDEX_BITS (INDEX_BITS)
	) icache_inst (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.fetch         (fetch_bus),
		.o_bus_request (o_bus_request),
		.o_bus_address (o_bus_address),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata),
		.o_ram_write   (ram_write),
		.o_ram_index   (ram_index),
		.o_ram_wdata   (ram_wdata),
		.i_ram_rdata   (ram_rdata),
		.o_hit_count   (o_hit_count),
		.o_miss_count  (o_miss_count)
	);

	cache_ram #(
		.INDEX_BITS (INDEX_BITS)
	) cache_ram_inst (
		.i_clock (i_clock),
		.i_write (ram_write),
		.i_index (ram_index),
		.i_wdata (ram_wdata),
		.o_rdata (ram_rdata)
	);

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  wire                 i_clock,
	input  wire                 i_reset,
	input  wire                 i_hold,
	input  wire                 i_redirect,
	input  wire bus_pkg::word_t i_redirect_pc,
	fetch_if.fetch_unit         fetch,
	output logic                o_instr_valid,
	output bus_pkg::word_t      o_instr,
	output bus_pkg::word_t      o_instr_pc
);
	import bus_pkg::*;

	word_t pc;
	word_t redirect_target;
	logic  redirect_pending;

	assign fetch.pc = pc;
	assign fetch.hold = i_hold;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc <= RESET_PC;
			redirect_pending <= 1'b0;
			o_instr_valid <= 1'b0;
		end else begin
			o_instr_valid <= 1'b0;
			if (fetch.ready) begin
				if (redirect_pending) begin
					// Delivered word belongs to the old path.
					pc <= redirect_target;
					redirect_pending <= 1'b0;
				end else begin
					pc <= pc + 32'd4;
					o_instr_valid <= 1'b1;
				end
			end
			// A new redirect wins over one taken in this cycle.
			if (i_redirect) begin
				redirect_pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_redirect) begin
			redirect_target <= {i_redirect_pc[DATA_WIDTH-1:2], 2'b00};
		end
		if (fetch.ready && !redirect_pending) begin
			o_instr <= fetch.rdata;
			o_instr_pc <= pc;
		end
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
	parameter int INDEX_BITS = 6
) (
	input  wire                     i_clock,
	input  wire                     i_reset,
	fetch_if.icache                 fetch,
	output logic                    o_bus_request,
	output bus_pkg::word_t          o_bus_address,
	input  wire                     i_bus_ready,
	input  wire bus_pkg::word_t     i_bus_rdata,
	output logic                    o_ram_write,
	output logic [INDEX_BITS-1:0]   o_ram_index,
	output icache_pkg::entry_t      o_ram_wdata,
	input  wire icache_pkg::entry_t i_ram_rdata,
	output bus_pkg::word_t          o_hit_count,
	output bus_pkg::word_t          o_miss_count
);
	import bus_pkg::*;
	import icache_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;

	cache_state_t state;
	cache_state_t next_state;
	logic [INDEX_BITS:0] clear_count;
	logic [INDEX_BITS:0] next_clear_count;
	logic [INDEX_BITS-1:0] pc_index;
	logic [INDEX_BITS-1:0] next_index;
	logic [INDEX_BITS-1:0] read_index;
	tag_t pc_tag;
	logic hit;
	logic miss;

	assign pc_index = fetch.pc[INDEX_BITS+1:2];
	assign next_index = pc_index + 1'b1;
	assign pc_tag = make_tag(fetch.pc);
	assign o_bus_address = fetch.pc;

	always_comb begin
		next_state = state;
		next_clear_count = clear_count;
		fetch.ready = 1'b0;
		fetch.rdata = '0;
		o_bus_request = 1'b0;
		o_ram_write = 1'b0;
		o_ram_index = pc_index;
		o_ram_wdata = '0;
		hit = 1'b0;
		miss = 1'b0;

		case (state)
			INITIALIZE: begin
				// A zero entry has the valid flag cleared.
				if (clear_count < LINES) begin
					o_ram_write = 1'b1;
					o_ram_index = clear_count[INDEX_BITS-1:0];
					next_clear_count = clear_count + 1'b1;
				end else begin
					next_state = IDLE;
				end
			end

			IDLE: begin
				if (!fetch.hold) begin
					next_state = LOOKUP;
				end
			end

			LOOKUP: begin
				if (fetch.hold) begin
					next_state = IDLE;
				end else if (read_index == pc_index) begin
					if (i_ram_rdata.tag == pc_tag) begin
						hit = 1'b1;
						fetch.ready = 1'b1;
						fetch.rdata = i_ram_rdata.data;
						// Line for pc+4 is read while this word is delivered.
						o_ram_index = next_index;
					end else begin
						miss = 1'b1;
						o_bus_request = 1'b1;
						next_state = READ_BUS;
					end
				end
				// Otherwise the pc was redirected; re-read its line first.
			end

			READ_BUS: begin
				o_bus_request = 1'b1;
				if (i_bus_ready) begin
					o_ram_write = 1'b1;
					o_ram_wdata = '{data: i_bus_rdata, tag: pc_tag};
					fetch.ready = 1'b1;
					fetch.rdata = i_bus_rdata;
					next_state = IDLE;
				end
			end

			default: begin
				next_state = INITIALIZE;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= INITIALIZE;
			clear_count <= '0;
			o_hit_count <= '0;
			o_miss_count <= '0;
		end else begin
			state <= next_state;
			clear_count <= next_clear_count;
			if (hit) begin
				o_hit_count <= o_hit_count + 1'b1;
			end
			if (miss) begin
				o_miss_count <= o_miss_count + 1'b1;
			end
		end
	end

	// Line that the RAM output belongs to in the next cycle.
	always_ff @(posedge i_clock) begin
		read_index <= o_ram_index;
	end

	// The fetch unit must not move the pc during an open bus request.
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> $stable(o_bus_address));

	// Nothing is delivered until the sweep has cleared every line.
	assert property (@(posedge i_clock) disable iff (i_reset)
		fetch.ready |-> clear_count[INDEX_BITS]);

endmodule

`default_nettype wire

//--- hw/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// Controller states.
	typedef enum logic [1:0] {
		INITIALIZE = 2'd0,
		IDLE       = 2'd1,
		LOOKUP     = 2'd2,
		READ_BUS   = 2'd3
	} cache_state_t;

	// Full word address with bit 0 reused as the valid flag.
	typedef logic [bus_pkg::ADDR_WIDTH-1:0] tag_t;

	// One cache line, data in the upper half.
	typedef struct packed {
		bus_pkg::word_t data;
		tag_t           tag;
	} entry_t;

	// Tag of a valid line holding the word at this address.
	function automatic tag_t make_tag(bus_pkg::word_t address);
		return {address[bus_pkg::ADDR_WIDTH-1:2], 2'b01};
	endfunction

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds and runs the fetch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	-f fetch.f \
	--top-module fetch_tb \
	-Mdir obj_dir \
	-o fetch_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "all tests passed" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
